// ==== verilog/pe_periph_macros.svh ====
`ifndef PE_PERIPH_MACROS_SVH
`define PE_PERIPH_MACROS_SVH

// Bus widths
`define PE_ADDR_W 32
`define PE_DATA_W 32

// Address bits passed on to data memory
`define PE_MEM_ADDR_W 24

// Register offset inside one peripheral
`define PE_OFFSET_W 4

// Free-running tick counter
`define PE_MTIME_W 64

// Positions in the core interrupt vector
`define PE_IRQ_MTI_BIT 7
`define PE_IRQ_MEI_BIT 11

`endif

// ==== verilog/pe_periph_pkg.sv ====
`include "pe_periph_macros.svh"

package pe_periph_pkg;

    // Region code, address bits 31..24
    typedef enum logic [7:0] {
        REGION_IMEM = 8'h00,
        REGION_DMEM = 8'h01,
        REGION_RTC  = 8'h02,
        REGION_PLIC = 8'h04
    } region_e;

    // RTC register map
    typedef enum logic [`PE_OFFSET_W-1:0] {
        MTIME_LO    = 4'h0,
        MTIME_HI    = 4'h4,
        MTIMECMP_LO = 4'h8,
        MTIMECMP_HI = 4'hC
    } rtc_reg_e;

    // PLIC register map, claim is read-to-clear
    typedef enum logic [`PE_OFFSET_W-1:0] {
        PLIC_ENABLE  = 4'h0,
        PLIC_PENDING = 4'h4,
        PLIC_CLAIM   = 4'h8
    } plic_reg_e;

endpackage

// ==== verilog/periph_bus_if.sv ====
`timescale 1ns/1ps
`include "pe_periph_macros.svh"

interface periph_bus_if;

    logic                    sel;
    logic                    we;
    logic [`PE_OFFSET_W-1:0] offset;
    logic [`PE_DATA_W-1:0]   wdata;
    logic [`PE_DATA_W-1:0]   rdata;

    // Decoder side
    modport master (output sel, output we, output offset, output wdata, input rdata);

    // Peripheral side, rdata is registered by the peripheral
    modport slave (input sel, input we, input offset, input wdata, output rdata);

endinterface

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/1ps
`include "pe_periph_macros.svh"

module bus_decoder (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      bus_en_i,
    input  logic [3:0]                bus_we_i,
    input  logic [`PE_ADDR_W-1:0]     bus_addr_i,
    input  logic [`PE_DATA_W-1:0]     bus_wdata_i,
    input  logic [`PE_DATA_W-1:0]     dmem_rdata_i,
    output logic [`PE_DATA_W-1:0]     bus_rdata_o,
    output logic                      dmem_en_o,
    output logic [3:0]                dmem_we_o,
    output logic [`PE_MEM_ADDR_W-1:0] dmem_addr_o,
    output logic [`PE_DATA_W-1:0]     dmem_wdata_o,
    periph_bus_if.master              rtc_bus,
    periph_bus_if.master              plic_bus
);

    pe_periph_pkg::region_e region;
    logic                   bus_wr;
    logic                   rtc_rd_q;
    logic                   plic_rd_q;

    assign region = pe_periph_pkg::region_e'(bus_addr_i[`PE_ADDR_W-1 -: 8]);
    assign bus_wr = |bus_we_i;

    // Data memory follows the bus in the access cycle
    assign dmem_en_o    = bus_en_i && (region == pe_periph_pkg::REGION_DMEM);
    assign dmem_we_o    = bus_we_i;
    assign dmem_addr_o  = bus_addr_i[`PE_MEM_ADDR_W-1:0];
    assign dmem_wdata_o = bus_wdata_i;

    // Peripherals only see whole-word writes
    assign rtc_bus.sel    = bus_en_i && (region == pe_periph_pkg::REGION_RTC);
    assign rtc_bus.we     = bus_wr;
    assign rtc_bus.offset = bus_addr_i[`PE_OFFSET_W-1:0];
    assign rtc_bus.wdata  = bus_wdata_i;

    assign plic_bus.sel    = bus_en_i && (region == pe_periph_pkg::REGION_PLIC);
    assign plic_bus.we     = bus_wr;
    assign plic_bus.offset = bus_addr_i[`PE_OFFSET_W-1:0];
    assign plic_bus.wdata  = bus_wdata_i;

    // Remember the source of a read until the next access
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rtc_rd_q  <= 1'b0;
            plic_rd_q <= 1'b0;
        end else if (bus_en_i) begin
            rtc_rd_q  <= rtc_bus.sel && !bus_wr;
            plic_rd_q <= plic_bus.sel && !bus_wr;
        end
    end

    always_comb begin
        if (rtc_rd_q)
            bus_rdata_o = rtc_bus.rdata;
        else if (plic_rd_q)
            bus_rdata_o = plic_bus.rdata;
        else
            bus_rdata_o = dmem_rdata_i;
    end

endmodule

// ==== verilog/rtc_timer.sv ====
`timescale 1ns/1ps
`include "pe_periph_macros.svh"

module rtc_timer (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    periph_bus_if.slave            bus,
    output logic                   mti_o,
    output logic [`PE_MTIME_W-1:0] mtime_o
);

    localparam int HALF_W = `PE_MTIME_W / 2;

    logic [`PE_MTIME_W-1:0] mtime_q;
    logic [`PE_MTIME_W-1:0] mtimecmp_q;
    logic                   wr;
    logic                   rd;

    assign wr = bus.sel && bus.we;
    assign rd = bus.sel && !bus.we;

    //////////////////////////////////////////////////////////////////////
    // Tick counter and compare register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtime_q <= '0;
        end else if (wr && (bus.offset == pe_periph_pkg::MTIME_LO)) begin
            mtime_q[HALF_W-1:0] <= bus.wdata;
        end else if (wr && (bus.offset == pe_periph_pkg::MTIME_HI)) begin
            mtime_q[`PE_MTIME_W-1:HALF_W] <= bus.wdata;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    // All ones keeps the timer interrupt quiet after reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mtimecmp_q <= '1;
        end else if (wr) begin
            if (bus.offset == pe_periph_pkg::MTIMECMP_LO)
                mtimecmp_q[HALF_W-1:0] <= bus.wdata;
            else if (bus.offset == pe_periph_pkg::MTIMECMP_HI)
                mtimecmp_q[`PE_MTIME_W-1:HALF_W] <= bus.wdata;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////

    // Sampled before the increment of the access edge
    always_ff @(posedge clk_i) begin
        if (rd) begin
            case (pe_periph_pkg::rtc_reg_e'(bus.offset))
                pe_periph_pkg::MTIME_LO:    bus.rdata <= mtime_q[HALF_W-1:0];
                pe_periph_pkg::MTIME_HI:    bus.rdata <= mtime_q[`PE_MTIME_W-1:HALF_W];
                pe_periph_pkg::MTIMECMP_LO: bus.rdata <= mtimecmp_q[HALF_W-1:0];
                pe_periph_pkg::MTIMECMP_HI: bus.rdata <= mtimecmp_q[`PE_MTIME_W-1:HALF_W];
                default:                    bus.rdata <= '0;
            endcase
        end
    end

    assign mti_o   = (mtime_q >= mtimecmp_q);
    assign mtime_o = mtime_q;

endmodule

// ==== verilog/plic_gateway.sv ====
`timescale 1ns/1ps
`include "pe_periph_macros.svh"

module plic_gateway (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        irq_src_i,
    periph_bus_if.slave bus,
    output logic        mei_o
);

    logic src_q;
    logic enable_q;
    logic enable_d;
    logic pending_q;
    logic pending_d;
    logic src_edge;
    logic claim;

    assign src_edge = irq_src_i && !src_q;
    assign claim    = bus.sel && !bus.we && (bus.offset == pe_periph_pkg::PLIC_CLAIM);

    always_comb begin
        enable_d = enable_q;
        if (bus.sel && bus.we && (bus.offset == pe_periph_pkg::PLIC_ENABLE))
            enable_d = bus.wdata[0];
    end

    // A fresh edge beats a claim in the same cycle
    always_comb begin
        pending_d = pending_q;
        if (src_edge)
            pending_d = 1'b1;
        else if (claim)
            pending_d = 1'b0;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            src_q     <= 1'b0;
            enable_q  <= 1'b0;
            pending_q <= 1'b0;
            mei_o     <= 1'b0;
        end else begin
            src_q     <= irq_src_i;
            enable_q  <= enable_d;
            pending_q <= pending_d;
            mei_o     <= pending_d && enable_d;
        end
    end

    // Claim returns pending as held before the edge
    always_ff @(posedge clk_i) begin
        if (bus.sel && !bus.we) begin
            case (pe_periph_pkg::plic_reg_e'(bus.offset))
                pe_periph_pkg::PLIC_ENABLE:  bus.rdata <= {{(`PE_DATA_W-1){1'b0}}, enable_q};
                pe_periph_pkg::PLIC_PENDING: bus.rdata <= {{(`PE_DATA_W-1){1'b0}}, pending_q};
                pe_periph_pkg::PLIC_CLAIM:   bus.rdata <= {{(`PE_DATA_W-1){1'b0}}, pending_q};
                default:                     bus.rdata <= '0;
            endcase
        end
    end

endmodule

// ==== verilog/pe_periph_top.sv ====
`timescale 1ns/1ps
`include "pe_periph_macros.svh"

module pe_periph_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    // Core data bus
    input  logic                      bus_en_i,
    input  logic [3:0]                bus_we_i,
    input  logic [`PE_ADDR_W-1:0]     bus_addr_i,
    input  logic [`PE_DATA_W-1:0]     bus_wdata_i,
    output logic [`PE_DATA_W-1:0]     bus_rdata_o,

    // Data memory
    output logic                      dmem_en_o,
    output logic [3:0]                dmem_we_o,
    output logic [`PE_MEM_ADDR_W-1:0] dmem_addr_o,
    output logic [`PE_DATA_W-1:0]     dmem_wdata_o,
    input  logic [`PE_DATA_W-1:0]     dmem_rdata_i,

    // Interrupts and time
    input  logic                      ext_irq_i,
    output logic [31:0]               irq_o,
    output logic [`PE_MTIME_W-1:0]    mtime_o
);

    logic mti;
    logic mei;

    periph_bus_if rtc_bus ();
    periph_bus_if plic_bus ();

    //////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////

    bus_decoder i_bus_decoder (
        .clk_i        (clk_i       ),
        .rst_ni       (rst_ni      ),
        .bus_en_i     (bus_en_i    ),
        .bus_we_i     (bus_we_i    ),
        .bus_addr_i   (bus_addr_i  ),
        .bus_wdata_i  (bus_wdata_i ),
        .dmem_rdata_i (dmem_rdata_i),
        .bus_rdata_o  (bus_rdata_o ),
        .dmem_en_o    (dmem_en_o   ),
        .dmem_we_o    (dmem_we_o   ),
        .dmem_addr_o  (dmem_addr_o ),
        .dmem_wdata_o (dmem_wdata_o),
        .rtc_bus      (rtc_bus     ),
        .plic_bus     (plic_bus    )
    );

    //////////////////////////////////////////////////////////////////////
    // Peripherals
    //////////////////////////////////////////////////////////////////////

    rtc_timer i_rtc_timer (
        .clk_i   (clk_i  ),
        .rst_ni  (rst_ni ),
        .bus     (rtc_bus),
        .mti_o   (mti    ),
        .mtime_o (mtime_o)
    );

    // Single external source
    plic_gateway i_plic_gateway (
        .clk_i     (clk_i    ),
        .rst_ni    (rst_ni   ),
        .irq_src_i (ext_irq_i),
        .bus       (plic_bus ),
        .mei_o     (mei      )
    );

    // Machine timer and external interrupt lines of the core vector
    always_comb begin
        irq_o                  = '0;
        irq_o[`PE_IRQ_MTI_BIT] = mti;
        irq_o[`PE_IRQ_MEI_BIT] = mei;
    end

endmodule

// ==== tb/pe_periph_chk.sv ====
`timescale 1ns/1ps
`include "pe_periph_macros.svh"

module pe_periph_chk (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   bus_en_i,
    input logic [3:0]             bus_we_i,
    input logic [`PE_ADDR_W-1:0]  bus_addr_i,
    input logic [`PE_DATA_W-1:0]  bus_wdata_i,
    input logic                   dmem_en_o,
    input logic [31:0]            irq_o,
    input logic [`PE_MTIME_W-1:0] mtime_o
);

    logic [`PE_MTIME_W-1:0] cmp_q;
    logic                   rtc_wr;

    assign rtc_wr = bus_en_i && (bus_addr_i[31:24] == 8'h02) && (|bus_we_i);

    // Local copy of the compare register
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            cmp_q <= '1;
        end else if (rtc_wr && (bus_addr_i[3:0] == 4'h8)) begin
            cmp_q[31:0] <= bus_wdata_i;
        end else if (rtc_wr && (bus_addr_i[3:0] == 4'hC)) begin
            cmp_q[63:32] <= bus_wdata_i;
        end
    end

    a_dmem_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dmem_en_o |-> bus_en_i && (bus_addr_i[31:24] == 8'h01))
        else $error("dmem_en_o without a data region access");

    a_irq_bits: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (irq_o & ~32'h0000_0880) == 32'h0)
        else $error("irq_o has a bit outside 7 and 11");

    a_mti: assert property (@(posedge clk_i) disable iff (!rst_ni)
        irq_o[`PE_IRQ_MTI_BIT] == (mtime_o >= cmp_q))
        else $error("timer interrupt disagrees with compare value");

endmodule

// ==== tb/pe_periph_tb.sv ====
`timescale 1ns/1ps
`include "pe_periph_macros.svh"

module pe_periph_tb;

    localparam int KIND_MEM  = 0;
    localparam int KIND_PASS = 1;
    localparam int KIND_VAL  = 2;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        bus_en_i;
    logic [3:0]  bus_we_i;
    logic [31:0] bus_addr_i;
    logic [31:0] bus_wdata_i;
    logic [31:0] bus_rdata_o;
    logic [31:0] dmem_rdata_i;
    logic        dmem_en_o;
    logic [3:0]  dmem_we_o;
    logic [23:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic        ext_irq_i;
    logic [31:0] irq_o;
    logic [63:0] mtime_o;

    logic [31:0] mem [256];
    logic [63:0] ticks;
    logic [15:0] lfsr;
    int          checks;
    int          errors;
    int          test_errors;
    logic        rd_req;
    int          rd_kind;
    logic [31:0] rd_val;
    logic        cmp_due;
    int          cmp_kind;
    logic [31:0] cmp_val;
    logic        shadow_pending;

    pe_periph_top i_dut (.*);

    bind pe_periph_top pe_periph_chk i_chk (
        .clk_i       (clk_i      ),
        .rst_ni      (rst_ni     ),
        .bus_en_i    (bus_en_i   ),
        .bus_we_i    (bus_we_i   ),
        .bus_addr_i  (bus_addr_i ),
        .bus_wdata_i (bus_wdata_i),
        .dmem_en_o   (dmem_en_o  ),
        .irq_o       (irq_o      ),
        .mtime_o     (mtime_o    )
    );

    always #5 clk_i = ~clk_i;

    // Data memory model, read data one cycle after the enable
    always @(posedge clk_i) begin
        if (dmem_en_o) begin
            for (int b = 0; b < 4; b++) begin
                if (dmem_we_o[b])
                    mem[dmem_addr_o[9:2]][b*8 +: 8] <= dmem_wdata_o[b*8 +: 8];
            end
            dmem_rdata_i <= mem[dmem_addr_o[9:2]];
        end
    end

    // Edges since reset release, reloaded by MTIME_LO writes
    always @(posedge clk_i) begin
        if (rst_ni) begin
            if (bus_en_i && (bus_addr_i[31:24] == 8'h02) && (|bus_we_i)
                    && (bus_addr_i[3:0] == 4'h0))
                ticks = {ticks[63:32], bus_wdata_i};
            else
                ticks = ticks + 64'd1;
        end
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[15]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [31:0] expected_rdata(input int kind, input logic [31:0] val);
        if (kind == KIND_MEM)
            return mem[val[9:2]];
        else if (kind == KIND_PASS)
            return dmem_rdata_i;
        return val;
    endfunction

    task automatic check(input logic [63:0] act, input logic [63:0] exp, input string msg);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, act, exp);
        end
    endtask

    // Read data is valid half a cycle after the access edge
    always @(posedge clk_i) begin
        cmp_due  <= rd_req;
        cmp_kind <= rd_kind;
        cmp_val  <= rd_val;
    end

    always @(negedge clk_i) begin
        if (cmp_due)
            check(64'(bus_rdata_o), 64'(expected_rdata(cmp_kind, cmp_val)), "read data");
    end

    // One access cycle, starting 1 ns after a rising edge
    task automatic bus_access(input logic [3:0] we, input logic [31:0] addr,
                              input logic [31:0] wdata, input int kind,
                              input logic [31:0] val);
        bus_en_i    = 1'b1;
        bus_we_i    = we;
        bus_addr_i  = addr;
        bus_wdata_i = wdata;
        rd_req      = (we == 4'h0);
        rd_kind     = kind;
        rd_val      = val;
        #2;
        check(64'(dmem_en_o), 64'(addr[31:24] == 8'h01), "dmem enable");
        if (addr[31:24] == 8'h01) begin
            check(64'(dmem_addr_o), 64'(addr[23:0]), "dmem address");
            check(64'(dmem_we_o), 64'(we), "dmem byte enables");
            check(64'(dmem_wdata_o), 64'(wdata), "dmem write data");
        end
        @(posedge clk_i);
        #1;
        bus_en_i = 1'b0;
        bus_we_i = 4'h0;
        rd_req   = 1'b0;
    endtask

    task automatic end_test(input string name);
        $display("Test %s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////

    task automatic test_dmem();
        logic [31:0] addrs [16];
        logic [31:0] r;
        logic [31:0] be;
        for (int i = 0; i < 16; i++) begin
            rand_bits(8, r);
            addrs[i] = {8'h01, 14'h0, r[7:0], 2'b00};
            rand_bits(4, be);
            rand_bits(32, r);
            bus_access((be[3:0] == 4'h0) ? 4'hF : be[3:0], addrs[i], r, KIND_VAL, 32'h0);
        end
        for (int i = 0; i < 16; i++)
            bus_access(4'h0, addrs[i], 32'h0, KIND_MEM, addrs[i]);
        end_test("data memory");
    endtask

    task automatic test_unmapped();
        logic [31:0] r;
        logic [7:0]  regions [4] = '{8'h00, 8'h03, 8'h80, 8'hFF};
        bus_access(4'h0, 32'h0100_0010, 32'h0, KIND_MEM, 32'h0100_0010);
        for (int i = 0; i < 4; i++) begin
            rand_bits(24, r);
            bus_access(4'h0, {regions[i], r[23:0]}, 32'h0, KIND_PASS, 32'h0);
            bus_access(4'hF, {regions[i], r[23:0]}, r, KIND_VAL, 32'h0);
        end
        end_test("unmapped regions");
    endtask

    task automatic test_mtime();
        for (int i = 0; i < 4; i++) begin
            check(mtime_o, ticks, "tick counter output");
            bus_access(4'h0, 32'h0200_0000, 32'h0, KIND_VAL, ticks[31:0]);
            bus_access(4'h0, 32'h0200_0004, 32'h0, KIND_VAL, ticks[63:32]);
        end
        bus_access(4'hF, 32'h0200_0000, 32'h0000_1000, KIND_VAL, 32'h0);
        repeat (3) @(posedge clk_i);
        #1;
        for (int i = 0; i < 4; i++)
            bus_access(4'h0, 32'h0200_0000, 32'h0, KIND_VAL, ticks[31:0]);
        end_test("tick counter");
    endtask

    task automatic test_timer_irq();
        logic [63:0] cmp;
        bus_access(4'hF, 32'h0200_000C, 32'h0, KIND_VAL, 32'h0);
        cmp = {32'h0, ticks[31:0] + 32'd20};
        bus_access(4'hF, 32'h0200_0008, cmp[31:0], KIND_VAL, 32'h0);
        for (int i = 0; i < 40; i++) begin
            check(64'(irq_o[`PE_IRQ_MTI_BIT]), 64'(ticks >= cmp), "timer interrupt");
            @(posedge clk_i);
            #1;
        end
        bus_access(4'hF, 32'h0200_000C, 32'hFFFF_FFFF, KIND_VAL, 32'h0);
        check(64'(irq_o[`PE_IRQ_MTI_BIT]), 64'h0, "timer interrupt after clear");
        end_test("timer interrupt");
    endtask

    task automatic test_ext_irq();
        ext_irq_i = 1'b1;
        @(posedge clk_i);
        #1;
        ext_irq_i = 1'b0;
        shadow_pending = 1'b1;
        bus_access(4'h0, 32'h0400_0004, 32'h0, KIND_VAL, 32'(shadow_pending));
        check(64'(irq_o[`PE_IRQ_MEI_BIT]), 64'h0, "external interrupt while disabled");
        bus_access(4'hF, 32'h0400_0000, 32'h1, KIND_VAL, 32'h0);
        check(64'(irq_o[`PE_IRQ_MEI_BIT]), 64'h1, "external interrupt enabled");
        bus_access(4'h0, 32'h0400_0008, 32'h0, KIND_VAL, 32'(shadow_pending));
        shadow_pending = 1'b0;
        check(64'(irq_o[`PE_IRQ_MEI_BIT]), 64'h0, "external interrupt after claim");
        bus_access(4'h0, 32'h0400_0008, 32'h0, KIND_VAL, 32'(shadow_pending));
        @(posedge clk_i);
        #1;
        end_test("external interrupt");
    endtask

    initial begin
        #30us;
        $display("Run timed out before all tests finished");
        $display("Verification failed");
        $finish;
    end

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = {8'h5A, i[7:0], ~i[7:0], i[7:0] ^ 8'h3C};
        rst_ni         = 1'b0;
        bus_en_i       = 1'b0;
        bus_we_i       = 4'h0;
        bus_addr_i     = '0;
        bus_wdata_i    = '0;
        dmem_rdata_i   = '0;
        ext_irq_i      = 1'b0;
        ticks          = '0;
        lfsr           = 16'd96;
        checks         = 0;
        errors         = 0;
        test_errors    = 0;
        rd_req         = 1'b0;
        rd_kind        = KIND_VAL;
        rd_val         = '0;
        shadow_pending = 1'b0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        check(64'(bus_rdata_o), 64'h0, "read data after reset");
        check(64'(irq_o), 64'h0, "irq after reset");

        test_dmem();
        test_unmapped();
        test_mtime();
        test_timer_irq();
        test_ext_irq();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== pe_periph_top.f ====
+incdir+verilog
verilog/pe_periph_pkg.sv
verilog/periph_bus_if.sv
verilog/bus_decoder.sv
verilog/rtc_timer.sv
verilog/plic_gateway.sv
verilog/pe_periph_top.sv
tb/pe_periph_chk.sv
tb/pe_periph_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the peripheral testbench with Verilator

cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert \
    -f pe_periph_top.f \
    --top-module pe_periph_tb \
    -Mdir build -o pe_periph_sim > build/compile.log 2>&1 \
    || { cat build/compile.log; echo "Build failed"; exit 1; }

./build/pe_periph_sim > build/sim.log 2>&1
status=$?
cat build/sim.log

[ "$status" -eq 0 ] && ! grep -q "Verification failed" build/sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed"; exit 1; }
